/* hw/board_pkg.sv */
`default_nettype none

package board_pkg;

  // ============================
  // Pad counts
  // ============================

  localparam int GPIO_W = 32;
  localparam int QSPI_W = 4;

  // One bit per pad, bit n is pad n
  typedef logic [GPIO_W-1:0] gpio_vec_t;
  typedef logic [QSPI_W-1:0] qspi_vec_t;

  // ============================
  // Clock and reset defaults
  // ============================

  // 8.388608 MHz / 256 gives 32.768 kHz
  localparam int LF_DIV_DEF = 256;

  // Peripheral reset stretch after erst_n release
  localparam int RST_HOLD_DEF = 16;

  // Reset sequencer states
  typedef enum logic [1:0] {
    RST_ASSERT = 2'd0, // Button pressed or not yet synced
    RST_HOLD   = 2'd1, // External reset released, peripherals held
    RST_RUN    = 2'd2  // All resets released
  } rst_state_t;

endpackage

`default_nettype wire

/* hw/lf_clk_div.sv */
`timescale 1ns/1ps
`default_nettype none

module lf_clk_div #(
  parameter int LF_DIV = board_pkg::LF_DIV_DEF
) (
  input  logic clk50mhz_i,
  input  logic rst_i,
  output logic lfclk_o
);

  localparam int HALF  = LF_DIV / 2;
  localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF - 1);

  logic [CNT_W-1:0] cnt;
  logic             lfclk_q;

  // ============================
  // Half-period counter
  // ============================

  always_ff @(posedge clk50mhz_i) begin
    if (rst_i) begin
      cnt     <= '0;
      lfclk_q <= 1'b0; // Starts low
    end else if (cnt == CNT_LAST) begin
      cnt     <= '0;
      lfclk_q <= ~lfclk_q;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Square wave, period LF_DIV cycles
  assign lfclk_o = lfclk_q;

endmodule

`default_nettype wire

/* hw/pad_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module pad_bank #(
  parameter int WIDTH   = 1,
  parameter bit GATE_IE = 1'b1
) (
  pad_if.pad               core,
  input  logic [WIDTH-1:0] pad_i,
  output logic [WIDTH-1:0] pad_o,
  output logic [WIDTH-1:0] pad_oe_o
);

  logic [WIDTH-1:0] buf_rd;

  // ============================
  // Bidirectional buffers
  // ============================

  // Pin driven from the core under oe
  assign pad_o    = core.oval;
  assign pad_oe_o = core.oe;

  // Read-back sees the driven level when enabled
  assign buf_rd = (core.oe & core.oval) | (~core.oe & pad_i);

  generate
    if (GATE_IE) begin : g_ie_gate
      assign core.ival = buf_rd & core.ie;
    end else begin : g_no_gate
      assign core.ival = buf_rd; // Input always on
    end
  endgenerate

endmodule

`default_nettype wire

/* hw/pad_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pad_if #(
  parameter int WIDTH = 1
);

  logic [WIDTH-1:0] oval; // Value driven by the SoC
  logic [WIDTH-1:0] oe;   // Output enable
  logic [WIDTH-1:0] ie;   // Input enable
  logic [WIDTH-1:0] ival; // Value returned to the SoC

  // SoC side
  modport core (
    output oval, oe, ie,
    input  ival
  );

  // Buffer side
  modport pad (
    input  oval, oe, ie,
    output ival
  );

endinterface

`default_nettype wire

/* hw/pad_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module pad_ring (
  pad_if.pad                 gpio,
  pad_if.pad                 qspi,
  input  board_pkg::gpio_vec_t gpio_pad_i,
  output board_pkg::gpio_vec_t gpio_pad_o,
  output board_pkg::gpio_vec_t gpio_pad_oe_o,
  input  board_pkg::qspi_vec_t qspi_dq_pad_i,
  output board_pkg::qspi_vec_t qspi_dq_pad_o,
  output board_pkg::qspi_vec_t qspi_dq_pad_oe_o,
  input  logic               qspi_sck_oval_i,
  output logic               qspi_sck_o,
  input  logic               qspi_cs_oval_i,
  output logic               qspi_cs_o,
  input  logic               mcu_tck_i,
  input  logic               mcu_tms_i,
  input  logic               mcu_tdi_i,
  output logic               jtag_tck_ival_o,
  output logic               jtag_tms_ival_o,
  output logic               jtag_tdi_ival_o,
  input  logic               jtag_tdo_oval_i,
  input  logic               jtag_tdo_oe_i,
  output logic               mcu_tdo_o,
  output logic               mcu_tdo_oe_o,
  input  logic               mcu_wakeup_i,
  output logic               pmu_dwakeup_n_o,
  input  logic               pmu_vddpaden_oval_i,
  input  logic               pmu_padrst_oval_i,
  output logic               pmu_paden_o,
  output logic               pmu_padrst_o
);

  import board_pkg::*;

  // ============================
  // Data pad banks
  // ============================

  pad_bank #(
    .WIDTH   (GPIO_W),
    .GATE_IE (1'b1)
  ) gpio_bank (
    .core     (gpio),
    .pad_i    (gpio_pad_i),
    .pad_o    (gpio_pad_o),
    .pad_oe_o (gpio_pad_oe_o)
  );

  // QSPI reads back regardless of ie
  pad_bank #(
    .WIDTH   (QSPI_W),
    .GATE_IE (1'b0)
  ) qspi_bank (
    .core     (qspi),
    .pad_i    (qspi_dq_pad_i),
    .pad_o    (qspi_dq_pad_o),
    .pad_oe_o (qspi_dq_pad_oe_o)
  );

  // ============================
  // Single pins
  // ============================

  assign qspi_sck_o = qspi_sck_oval_i;
  assign qspi_cs_o  = qspi_cs_oval_i;

  // JTAG inputs only
  assign jtag_tck_ival_o = mcu_tck_i;
  assign jtag_tms_ival_o = mcu_tms_i;
  assign jtag_tdi_ival_o = mcu_tdi_i;

  assign mcu_tdo_o    = jtag_tdo_oval_i;
  assign mcu_tdo_oe_o = jtag_tdo_oe_i; // Tristate control for TDO

  // Wake button is active high, SoC wants active low
  assign pmu_dwakeup_n_o = ~mcu_wakeup_i;

  assign pmu_paden_o  = pmu_vddpaden_oval_i;
  assign pmu_padrst_o = pmu_padrst_oval_i;

endmodule

`default_nettype wire

/* hw/reset_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl #(
  parameter int RST_HOLD = board_pkg::RST_HOLD_DEF
) (
  input  logic clk50mhz_i,
  input  logic rst_i,
  input  logic fpga_rst_n_i,
  input  logic mcu_rst_n_i,
  output logic erst_n_o,
  output logic periph_rst_o
);

  import board_pkg::*;

  localparam int HOLD_W = (RST_HOLD > 1) ? $clog2(RST_HOLD) : 1;

  localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(RST_HOLD - 1);

  logic              btn_rst_n;
  logic              sync_ff1;
  logic              sync_ff2;
  rst_state_t        state_q;
  rst_state_t        state_nxt;
  logic [HOLD_W-1:0] hold_cnt;
  logic [HOLD_W-1:0] hold_nxt;
  logic              periph_q;

  // Either button pulls reset
  assign btn_rst_n = fpga_rst_n_i & mcu_rst_n_i;

  // ============================
  // Button synchronizer
  // ============================

  always_ff @(posedge clk50mhz_i) begin
    if (rst_i) begin
      sync_ff1 <= 1'b0;
      sync_ff2 <= 1'b0;
    end else begin
      sync_ff1 <= btn_rst_n;
      sync_ff2 <= sync_ff1;
    end
  end

  assign erst_n_o = sync_ff2;

  // ============================
  // Peripheral reset sequencer
  // ============================

  // The module parameter shadows the RST_HOLD state name
  always_comb begin
    state_nxt = state_q;
    hold_nxt  = hold_cnt;
    case (state_q)
      RST_ASSERT: begin
        if (sync_ff2) begin
          state_nxt = board_pkg::RST_HOLD;
          hold_nxt  = '0;
        end
      end
      board_pkg::RST_HOLD: begin
        if (!sync_ff2) begin
          state_nxt = RST_ASSERT;
        end else if (hold_cnt == HOLD_LAST) begin
          state_nxt = RST_RUN;
        end else begin
          hold_nxt = hold_cnt + 1'b1;
        end
      end
      RST_RUN: if (!sync_ff2) state_nxt = RST_ASSERT; // Button pressed again
      default: state_nxt = RST_ASSERT;
    endcase
  end

  always_ff @(posedge clk50mhz_i) begin
    if (rst_i) begin
      state_q  <= RST_ASSERT;
      hold_cnt <= '0;
      periph_q <= 1'b1;
    end else begin
      state_q  <= state_nxt;
      hold_cnt <= hold_nxt;
      periph_q <= (state_nxt != RST_RUN);
    end
  end

  assign periph_rst_o = periph_q;

endmodule

`default_nettype wire

/* hw/system_top.sv */
`timescale 1ns/1ps
`default_nettype none

module system_top #(
  parameter int LF_DIV   = board_pkg::LF_DIV_DEF,
  parameter int RST_HOLD = board_pkg::RST_HOLD_DEF
) (
  input  logic                 clk50mhz_i,
  input  logic                 rst_i,
  input  logic                 fpga_rst_n_i,
  input  logic                 mcu_rst_n_i,

  // SoC side, GPIO
  input  board_pkg::gpio_vec_t gpio_oval_i,
  input  board_pkg::gpio_vec_t gpio_oe_i,
  input  board_pkg::gpio_vec_t gpio_ie_i,
  output board_pkg::gpio_vec_t gpio_ival_o,

  // SoC side, QSPI data
  input  board_pkg::qspi_vec_t qspi_dq_oval_i,
  input  board_pkg::qspi_vec_t qspi_dq_oe_i,
  output board_pkg::qspi_vec_t qspi_dq_ival_o,

  // Board pins
  input  board_pkg::gpio_vec_t gpio_pad_i,
  output board_pkg::gpio_vec_t gpio_pad_o,
  output board_pkg::gpio_vec_t gpio_pad_oe_o,
  input  board_pkg::qspi_vec_t qspi_dq_pad_i,
  output board_pkg::qspi_vec_t qspi_dq_pad_o,
  output board_pkg::qspi_vec_t qspi_dq_pad_oe_o,

  input  logic                 qspi_sck_oval_i,
  output logic                 qspi_sck_o,
  input  logic                 qspi_cs_oval_i,
  output logic                 qspi_cs_o,

  // JTAG
  input  logic                 mcu_tck_i,
  input  logic                 mcu_tms_i,
  input  logic                 mcu_tdi_i,
  output logic                 jtag_tck_ival_o,
  output logic                 jtag_tms_ival_o,
  output logic                 jtag_tdi_ival_o,
  input  logic                 jtag_tdo_oval_i,
  input  logic                 jtag_tdo_oe_i,
  output logic                 mcu_tdo_o,
  output logic                 mcu_tdo_oe_o,

  // Power management
  input  logic                 mcu_wakeup_i,
  output logic                 pmu_dwakeup_n_o,
  input  logic                 pmu_vddpaden_oval_i,
  input  logic                 pmu_padrst_oval_i,
  output logic                 pmu_paden_o,
  output logic                 pmu_padrst_o,

  output logic                 clk_32768hz_o,
  output logic                 erst_n_o,
  output logic                 periph_rst_o
);

  import board_pkg::*;

  pad_if #(.WIDTH(GPIO_W)) gpio_if ();
  pad_if #(.WIDTH(QSPI_W)) qspi_if ();

  // ============================
  // Core side of the pad banks
  // ============================

  assign gpio_if.oval = gpio_oval_i;
  assign gpio_if.oe   = gpio_oe_i;
  assign gpio_if.ie   = gpio_ie_i;
  assign gpio_ival_o  = gpio_if.ival;

  assign qspi_if.oval    = qspi_dq_oval_i;
  assign qspi_if.oe      = qspi_dq_oe_i;
  assign qspi_if.ie      = '1; // No ie from the flash controller
  assign qspi_dq_ival_o  = qspi_if.ival;

  // ============================
  // Clock and reset
  // ============================

  lf_clk_div #(
    .LF_DIV (LF_DIV)
  ) lf_clk_div_inst (
    .clk50mhz_i (clk50mhz_i),
    .rst_i      (rst_i),
    .lfclk_o    (clk_32768hz_o)
  );

  reset_ctrl #(
    .RST_HOLD (RST_HOLD)
  ) reset_ctrl_inst (
    .clk50mhz_i   (clk50mhz_i),
    .rst_i        (rst_i),
    .fpga_rst_n_i (fpga_rst_n_i),
    .mcu_rst_n_i  (mcu_rst_n_i),
    .erst_n_o     (erst_n_o),
    .periph_rst_o (periph_rst_o)
  );

  pad_ring pad_ring_inst (
    .gpio                (gpio_if.pad),
    .qspi                (qspi_if.pad),
    .gpio_pad_i          (gpio_pad_i),
    .gpio_pad_o          (gpio_pad_o),
    .gpio_pad_oe_o       (gpio_pad_oe_o),
    .qspi_dq_pad_i       (qspi_dq_pad_i),
    .qspi_dq_pad_o       (qspi_dq_pad_o),
    .qspi_dq_pad_oe_o    (qspi_dq_pad_oe_o),
    .qspi_sck_oval_i     (qspi_sck_oval_i),
    .qspi_sck_o          (qspi_sck_o),
    .qspi_cs_oval_i      (qspi_cs_oval_i),
    .qspi_cs_o           (qspi_cs_o),
    .mcu_tck_i           (mcu_tck_i),
    .mcu_tms_i           (mcu_tms_i),
    .mcu_tdi_i           (mcu_tdi_i),
    .jtag_tck_ival_o     (jtag_tck_ival_o),
    .jtag_tms_ival_o     (jtag_tms_ival_o),
    .jtag_tdi_ival_o     (jtag_tdi_ival_o),
    .jtag_tdo_oval_i     (jtag_tdo_oval_i),
    .jtag_tdo_oe_i       (jtag_tdo_oe_i),
    .mcu_tdo_o           (mcu_tdo_o),
    .mcu_tdo_oe_o        (mcu_tdo_oe_o),
    .mcu_wakeup_i        (mcu_wakeup_i),
    .pmu_dwakeup_n_o     (pmu_dwakeup_n_o),
    .pmu_vddpaden_oval_i (pmu_vddpaden_oval_i),
    .pmu_padrst_oval_i   (pmu_padrst_oval_i),
    .pmu_paden_o         (pmu_paden_o),
    .pmu_padrst_o        (pmu_padrst_o)
  );

endmodule

`default_nettype wire

/* project.f */
hw/board_pkg.sv
hw/pad_if.sv
hw/lf_clk_div.sv
hw/reset_ctrl.sv
hw/pad_bank.sv
hw/pad_ring.sv
hw/system_top.sv
tests/system_sva.sv
tests/tb_system.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_system -f project.f -o tb_system &&
  ./obj_dir/tb_system || exit 1

/* tests/system_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module system_sva (
  input logic                 clk_i,
  input logic                 rst_i,
  input board_pkg::gpio_vec_t gpio_oval_i,
  input board_pkg::gpio_vec_t gpio_pad_i,
  input logic                 mcu_wakeup_i,
  input logic                 pmu_dwakeup_n_i,
  input logic                 erst_n_i,
  input logic                 periph_rst_i
);

  // ==============================
  // Pad ring
  // ==============================

  a_gpio_out: assert property (@(posedge clk_i) disable iff (rst_i)
    gpio_pad_i == gpio_oval_i)
    else $error("GPIO pin value differs from the SoC output value");

  a_wakeup: assert property (@(posedge clk_i) disable iff (rst_i)
    pmu_dwakeup_n_i == ~mcu_wakeup_i)
    else $error("Wakeup request is not the inverse of the wakeup pin");

  // ==============================
  // Reset sequencing
  // ==============================

  a_periph_rst: assert property (@(posedge clk_i) disable iff (rst_i)
    !erst_n_i |=> periph_rst_i)
    else $error("Peripheral reset low while external reset asserted");

endmodule

bind system_top system_sva system_sva_inst (
  .clk_i           (clk50mhz_i),
  .rst_i           (rst_i),
  .gpio_oval_i     (gpio_oval_i),
  .gpio_pad_i      (gpio_pad_o),
  .mcu_wakeup_i    (mcu_wakeup_i),
  .pmu_dwakeup_n_i (pmu_dwakeup_n_o),
  .erst_n_i        (erst_n_o),
  .periph_rst_i    (periph_rst_o)
);

`default_nettype wire

/* tests/tb_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_system;

  import board_pkg::*;

  localparam int HALF    = LF_DIV_DEF / 2;
  localparam int TIMEOUT = 2500; // Tests take about 1530 cycles

  // DUT ports
  logic      clk50mhz_i, rst_i, fpga_rst_n_i, mcu_rst_n_i;
  gpio_vec_t gpio_oval_i, gpio_oe_i, gpio_ie_i, gpio_pad_i;
  gpio_vec_t gpio_ival_o, gpio_pad_o, gpio_pad_oe_o;
  qspi_vec_t qspi_dq_oval_i, qspi_dq_oe_i, qspi_dq_pad_i;
  qspi_vec_t qspi_dq_ival_o, qspi_dq_pad_o, qspi_dq_pad_oe_o;
  logic      qspi_sck_oval_i, qspi_sck_o, qspi_cs_oval_i, qspi_cs_o;
  logic      mcu_tck_i, mcu_tms_i, mcu_tdi_i, jtag_tdo_oval_i, jtag_tdo_oe_i;
  logic      jtag_tck_ival_o, jtag_tms_ival_o, jtag_tdi_ival_o;
  logic      mcu_tdo_o, mcu_tdo_oe_o;
  logic      mcu_wakeup_i, pmu_vddpaden_oval_i, pmu_padrst_oval_i;
  logic      pmu_dwakeup_n_o, pmu_paden_o, pmu_padrst_o;
  logic      clk_32768hz_o, erst_n_o, periph_rst_o;

  logic [31:0] rng;
  logic [1:0]  pad_mode; // 0 idle, 1 GPIO, 2 QSPI, 3 JTAG and PMU
  int          cycle_cnt = 0;

  system_top system_top_inst (.*);

  initial begin
    clk50mhz_i = 1'b0;
    forever #50 clk50mhz_i = ~clk50mhz_i;
  end

  always @(posedge clk50mhz_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT) begin
      $display("test failed");
      $fatal(1, "Run did not finish within %0d cycles", TIMEOUT);
    end
  end

  // ==============================
  // Reference model and checks
  // ==============================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Driven value under oe, board pin otherwise, then masked by ie
  function automatic gpio_vec_t pad_return(input gpio_vec_t oval, input gpio_vec_t oe,
                                           input gpio_vec_t ie, input gpio_vec_t pin);
    gpio_vec_t r;
    for (int i = 0; i < GPIO_W; i++) begin
      r[i] = (oe[i] ? oval[i] : pin[i]) & ie[i];
    end
    return r;
  endfunction

  task automatic check_gpio(input gpio_vec_t got, input gpio_vec_t exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic check_qspi(input qspi_vec_t got, input qspi_vec_t exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Pad paths are combinational, so look at them mid cycle
  always @(negedge clk50mhz_i) begin
    gpio_vec_t exp_q;
    case (pad_mode)
      2'd1: begin
        check_gpio(gpio_pad_o, gpio_oval_i, "gpio_pad_o");
        check_gpio(gpio_pad_oe_o, gpio_oe_i, "gpio_pad_oe_o");
        check_gpio(gpio_ival_o, pad_return(gpio_oval_i, gpio_oe_i, gpio_ie_i, gpio_pad_i),
                   "gpio_ival_o");
      end
      2'd2: begin
        exp_q = pad_return(gpio_vec_t'(qspi_dq_oval_i), gpio_vec_t'(qspi_dq_oe_i), '1,
                           gpio_vec_t'(qspi_dq_pad_i)); // No ie on QSPI
        check_qspi(qspi_dq_ival_o, exp_q[QSPI_W-1:0], "qspi_dq_ival_o");
        check_qspi(qspi_dq_pad_o, qspi_dq_oval_i, "qspi_dq_pad_o");
        check_qspi(qspi_dq_pad_oe_o, qspi_dq_oe_i, "qspi_dq_pad_oe_o");
        check_bit(qspi_sck_o, qspi_sck_oval_i, "qspi_sck_o");
        check_bit(qspi_cs_o, qspi_cs_oval_i, "qspi_cs_o");
      end
      2'd3: begin
        check_bit(jtag_tck_ival_o, mcu_tck_i, "jtag_tck_ival_o");
        check_bit(jtag_tms_ival_o, mcu_tms_i, "jtag_tms_ival_o");
        check_bit(jtag_tdi_ival_o, mcu_tdi_i, "jtag_tdi_ival_o");
        check_bit(mcu_tdo_o, jtag_tdo_oval_i, "mcu_tdo_o");
        check_bit(mcu_tdo_oe_o, jtag_tdo_oe_i, "mcu_tdo_oe_o");
        check_bit(pmu_paden_o, pmu_vddpaden_oval_i, "pmu_paden_o");
        check_bit(pmu_padrst_o, pmu_padrst_oval_i, "pmu_padrst_o");
        check_bit(pmu_dwakeup_n_o, ~mcu_wakeup_i, "pmu_dwakeup_n_o");
      end
      default: ;
    endcase
  end

  // ==============================
  // Stimulus
  // ==============================

  task automatic next_edge();
    @(posedge clk50mhz_i);
    #10;
  endtask

  task automatic drive_random();
    logic [31:0] bits;
    gpio_oval_i         = next_rand();
    gpio_oe_i           = next_rand();
    gpio_ie_i           = next_rand();
    gpio_pad_i          = next_rand();
    bits                = next_rand();
    qspi_dq_oval_i      = bits[3:0];
    qspi_dq_oe_i        = bits[7:4];
    qspi_dq_pad_i       = bits[11:8];
    qspi_sck_oval_i     = bits[12];
    qspi_cs_oval_i      = bits[13];
    mcu_tck_i           = bits[14];
    mcu_tms_i           = bits[15];
    mcu_tdi_i           = bits[16];
    jtag_tdo_oval_i     = bits[17];
    jtag_tdo_oe_i       = bits[18];
    mcu_wakeup_i        = bits[19];
    pmu_vddpaden_oval_i = bits[20];
    pmu_padrst_oval_i   = bits[21];
  endtask

  task automatic run_pads(input logic [1:0] mode, input int count);
    for (int n = 0; n < count; n++) begin
      next_edge();
      drive_random();
      pad_mode = mode;
    end
    next_edge();
    pad_mode = 2'd0;
  endtask

  // Called right after a button is released
  task automatic release_check();
    next_edge();
    check_bit(erst_n_o, 1'b0, "erst_n_o one edge after release");
    next_edge();
    check_bit(erst_n_o, 1'b1, "erst_n_o two edges after release");
    for (int n = 0; n < RST_HOLD_DEF; n++) begin
      next_edge();
      check_bit(periph_rst_o, 1'b1, "periph_rst_o during hold");
    end
    next_edge();
    check_bit(periph_rst_o, 1'b0, "periph_rst_o after hold");
  endtask

  task automatic press_check(input logic use_mcu);
    if (use_mcu) mcu_rst_n_i = 1'b0;
    else fpga_rst_n_i = 1'b0;
    next_edge();
    check_bit(erst_n_o, 1'b1, "erst_n_o one edge after press");
    next_edge();
    check_bit(erst_n_o, 1'b0, "erst_n_o two edges after press");
    check_bit(periph_rst_o, 1'b0, "periph_rst_o as erst_n_o falls");
    next_edge();
    check_bit(periph_rst_o, 1'b1, "periph_rst_o after press");
    mcu_rst_n_i  = 1'b1;
    fpga_rst_n_i = 1'b1;
    release_check();
  endtask

  initial begin
    rng          = 32'd26;
    pad_mode     = 2'd0;
    rst_i        = 1'b1;
    fpga_rst_n_i = 1'b0; // Held pressed through reset
    mcu_rst_n_i  = 1'b1;
    drive_random();
    repeat (5) next_edge();
    rst_i = 1'b0;
    check_bit(erst_n_o, 1'b0, "erst_n_o after rst_i");
    check_bit(periph_rst_o, 1'b1, "periph_rst_o after rst_i");
    next_edge();
    fpga_rst_n_i = 1'b1;
    release_check();
    press_check(1'b1);
    press_check(1'b0);

    run_pads(2'd1, 200);
    run_pads(2'd2, 200);
    run_pads(2'd3, 32);

    // Fresh reset so the divider phase is known
    rst_i = 1'b1;
    next_edge();
    rst_i = 1'b0;
    check_bit(clk_32768hz_o, 1'b0, "clk_32768hz_o after rst_i");
    for (int n = 1; n <= 4 * LF_DIV_DEF; n++) begin
      next_edge();
      check_bit(clk_32768hz_o, ((n / HALF) % 2) == 1, "clk_32768hz_o");
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
